//--- Bender.yml
package:
  name: sm_attn

sources:
  - rtl/sm_attn_pkg.sv
  - rtl/sync_fifo.sv
  - rtl/node_count_ram.sv
  - rtl/fxp_div_pipe.sv
  - rtl/softmax_pipe.sv
  - rtl/sm_attn_top.sv
  - target: test
    files:
      - verif/tb_sm_attn.sv

//--- rtl/fxp_div_pipe.sv
`timescale 1ns/10ps

module fxp_div_pipe import sm_attn_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  div_req_t in_req,
  output logic     out_valid,
  input  logic     out_ready,
  output alpha_t   out
);

  // remainder is wide enough for the divisor shifted by the top quotient bit
  typedef struct packed {
    logic [SUM_W+ALPHA_W-1:0] rem;
    logic [SUM_W-1:0]         dvs;
    logic [ALPHA_W-1:0]       quo;
    logic                     last;
  } stage_t;

  stage_t             head;
  stage_t             stg_q [ALPHA_W];
  logic [ALPHA_W-1:0] vld_q;
  logic               advance;

  // one restoring step resolving quotient bit b
  function automatic stage_t resolve(input stage_t s, input int unsigned b);
    logic [SUM_W+ALPHA_W-1:0] trial;
    stage_t                   r;
    trial = (SUM_W + ALPHA_W)'(s.dvs) << b;
    r = s;
    if (s.rem >= trial) begin
      r.rem    = s.rem - trial;
      r.quo[b] = 1'b1;
    end
    return r;
  endfunction

  // numerator is dividend * 2^ALPHA_FRAC
  always_comb begin
    head.rem  = (SUM_W + ALPHA_W)'({in_req.dividend, {ALPHA_FRAC{1'b0}}});
    head.dvs  = in_req.divisor;
    head.quo  = '0;
    head.last = in_req.last;
  end

  // whole pipe freezes while the output is held
  assign advance  = !out_valid || out_ready;
  assign in_ready = advance;

  always_ff @(posedge clk) begin
    if (advance) begin
      stg_q[0] <= resolve(head, ALPHA_W - 1);
      for (int k = 1; k < ALPHA_W; k++) begin
        stg_q[k] <= resolve(stg_q[k-1], ALPHA_W - 1 - k);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else if (advance) begin
      vld_q <= {vld_q[ALPHA_W-2:0], in_valid};
    end
  end

  assign out_valid = vld_q[ALPHA_W-1];
  assign out.value = stg_q[ALPHA_W-1].quo;
  assign out.last  = stg_q[ALPHA_W-1].last;

endmodule

//--- rtl/node_count_ram.sv
`timescale 1ns/10ps

module node_count_ram import sm_attn_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             wr_valid,
  input  cfg_t             wr,
  input  logic [SG_W-1:0]  rd_sg,
  output logic [CNT_W-1:0] rd_num_nodes
);

  logic [CNT_W-1:0] mem [NUM_SUBGRAPHS];

  // host side
  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr.sg] <= wr.num_nodes;
    end
  end

  // registered read like a block RAM
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_num_nodes <= '0;
    end else begin
      rd_num_nodes <= mem[rd_sg];
    end
  end

endmodule

//--- rtl/sm_attn_pkg.sv
package sm_attn_pkg;

  localparam int COEF_W        = 4;
  localparam int EXP_W         = 16;
  localparam int CNT_W         = 5;
  localparam int NUM_SUBGRAPHS = 8;
  localparam int SG_W          = 3;
  localparam int SUM_W         = EXP_W + CNT_W;
  localparam int ALPHA_FRAC    = 8;
  // alpha is at most 1.0, so one integer bit
  localparam int ALPHA_W       = ALPHA_FRAC + 1;

  localparam int COEF_FIFO_DEPTH     = 4;
  localparam int DIVIDEND_FIFO_DEPTH = 32;
  localparam int DIVISOR_FIFO_DEPTH  = 4;

  typedef struct packed {
    logic [COEF_W-1:0] value;
  } coef_t;

  // one record per subgraph
  typedef struct packed {
    logic [CNT_W-1:0] num_nodes;
    logic [SUM_W-1:0] sum;
  } divisor_t;

  typedef struct packed {
    logic [EXP_W-1:0] dividend;
    logic [SUM_W-1:0] divisor;
    logic             last;
  } div_req_t;

  typedef struct packed {
    logic [ALPHA_W-1:0] value;
    logic               last;
  } alpha_t;

  typedef struct packed {
    logic [SG_W-1:0]  sg;
    logic [CNT_W-1:0] num_nodes;
  } cfg_t;

endpackage

//--- rtl/sm_attn_top.sv
`timescale 1ns/10ps

module sm_attn_top import sm_attn_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   coef_valid,
  output logic   coef_ready,
  input  coef_t  coef_in,
  input  logic   cfg_valid,
  input  cfg_t   cfg,
  output logic   alpha_valid,
  input  logic   alpha_ready,
  output alpha_t alpha
);

  logic             fifo_valid;
  logic             fifo_ready;
  coef_t            fifo_coef;
  logic [SG_W-1:0]  rd_sg;
  logic [CNT_W-1:0] rd_num_nodes;

  // input coefficients
  sync_fifo #(
    .payload_t (coef_t),
    .DEPTH     (COEF_FIFO_DEPTH)
  ) u_coef_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (coef_valid),
    .in_ready  (coef_ready),
    .in_data   (coef_in),
    .out_valid (fifo_valid),
    .out_ready (fifo_ready),
    .out_data  (fifo_coef)
  );

  // host writes counts only while the stream is idle
  node_count_ram u_node_count_ram (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_valid     (cfg_valid),
    .wr           (cfg),
    .rd_sg        (rd_sg),
    .rd_num_nodes (rd_num_nodes)
  );

  softmax_pipe u_softmax_pipe (
    .clk          (clk),
    .rst_n        (rst_n),
    .coef_valid   (fifo_valid),
    .coef_ready   (fifo_ready),
    .coef         (fifo_coef),
    .rd_sg        (rd_sg),
    .rd_num_nodes (rd_num_nodes),
    .alpha_valid  (alpha_valid),
    .alpha_ready  (alpha_ready),
    .alpha        (alpha)
  );

endmodule

//--- rtl/softmax_pipe.sv
`timescale 1ns/10ps

module softmax_pipe import sm_attn_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             coef_valid,
  output logic             coef_ready,
  input  coef_t            coef,
  output logic [SG_W-1:0]  rd_sg,
  input  logic [CNT_W-1:0] rd_num_nodes,
  output logic             alpha_valid,
  input  logic             alpha_ready,
  output alpha_t           alpha
);

  // accumulate side
  logic [SG_W-1:0]  sg_q;
  logic [SG_W-1:0]  sg_d;
  logic [CNT_W-1:0] node_cnt_q;
  logic [SUM_W-1:0] sum_q;
  logic [SUM_W-1:0] sum_new;
  logic [EXP_W-1:0] exp_val;
  logic             is_last;
  logic             accept;

  logic             dvd_in_ready;
  logic             dvd_out_valid;
  logic             dvd_out_ready;
  logic [EXP_W-1:0] dvd_out_data;

  logic             dvs_in_valid;
  logic             dvs_in_ready;
  divisor_t         dvs_in_data;
  logic             dvs_out_valid;
  logic             dvs_out_ready;
  divisor_t         dvs_out_data;

  // issue side
  logic [CNT_W-1:0] issue_left_q;
  logic [SUM_W-1:0] issue_sum_q;
  logic [CNT_W-1:0] cur_left;
  logic [SUM_W-1:0] cur_sum;
  logic             at_start;
  logic             job_valid;
  logic             div_in_ready;
  logic             issue;
  div_req_t         req;

  assign exp_val = EXP_W'(1) << coef.value;
  assign sum_new = sum_q + SUM_W'(exp_val);
  assign is_last = (node_cnt_q == CNT_W'(rd_num_nodes - 1'b1));

  // the last node also needs room for its subgraph record
  assign coef_ready = dvd_in_ready && (!is_last || dvs_in_ready);
  assign accept     = coef_valid && coef_ready;

  assign dvs_in_valid          = accept && is_last;
  assign dvs_in_data.num_nodes = rd_num_nodes;
  assign dvs_in_data.sum       = sum_new;

  // table address follows the next index so the count is ready a cycle later
  always_comb begin
    sg_d = sg_q;
    if (accept && is_last) begin
      sg_d = (sg_q == SG_W'(NUM_SUBGRAPHS - 1)) ? '0 : sg_q + 1'b1;
    end
  end
  assign rd_sg = sg_d;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sg_q       <= '0;
      node_cnt_q <= '0;
      sum_q      <= '0;
    end else begin
      sg_q <= sg_d;
      if (accept) begin
        node_cnt_q <= is_last ? '0 : node_cnt_q + 1'b1;
        sum_q      <= is_last ? '0 : sum_new;
      end
    end
  end

  sync_fifo #(
    .payload_t (logic [EXP_W-1:0]),
    .DEPTH     (DIVIDEND_FIFO_DEPTH)
  ) u_dividend_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (accept),
    .in_ready  (dvd_in_ready),
    .in_data   (exp_val),
    .out_valid (dvd_out_valid),
    .out_ready (dvd_out_ready),
    .out_data  (dvd_out_data)
  );

  sync_fifo #(
    .payload_t (divisor_t),
    .DEPTH     (DIVISOR_FIFO_DEPTH)
  ) u_divisor_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (dvs_in_valid),
    .in_ready  (dvs_in_ready),
    .in_data   (dvs_in_data),
    .out_valid (dvs_out_valid),
    .out_ready (dvs_out_ready),
    .out_data  (dvs_out_data)
  );

  // a zero count left means the next dividend opens a subgraph
  assign at_start  = (issue_left_q == '0);
  assign cur_left  = at_start ? dvs_out_data.num_nodes : issue_left_q;
  assign cur_sum   = at_start ? dvs_out_data.sum : issue_sum_q;
  assign job_valid = dvd_out_valid && (!at_start || dvs_out_valid);
  assign issue     = job_valid && div_in_ready;

  assign dvd_out_ready = div_in_ready && (!at_start || dvs_out_valid);
  assign dvs_out_ready = at_start && issue;

  assign req.dividend = dvd_out_data;
  assign req.divisor  = cur_sum;
  assign req.last     = (cur_left == CNT_W'(1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_left_q <= '0;
    end else if (issue) begin
      issue_left_q <= cur_left - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      issue_sum_q <= cur_sum;
    end
  end

  fxp_div_pipe u_fxp_div_pipe (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (job_valid),
    .in_ready  (div_in_ready),
    .in_req    (req),
    .out_valid (alpha_valid),
    .out_ready (alpha_ready),
    .out       (alpha)
  );

endmodule

//--- rtl/sync_fifo.sv
`timescale 1ns/10ps

module sync_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             push;
  logic             pop;

  assign in_ready  = (count != (PTR_W+1)'(DEPTH));
  assign out_valid = (count != '0);
  // first word falls through
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
    end
  end

endmodule

//--- sm_attn.f
rtl/sm_attn_pkg.sv
rtl/sync_fifo.sv
rtl/node_count_ram.sv
rtl/fxp_div_pipe.sv
rtl/softmax_pipe.sv
rtl/sm_attn_top.sv
verif/tb_sm_attn.sv

//--- verif/tb_sm_attn.sv
`timescale 1ns/10ps

module tb_sm_attn import sm_attn_pkg::*; ();

  localparam int NUM_SG_TB  = 10;
  localparam int NUM_COEF   = 34;
  localparam int READY_WAIT = 200;
  localparam int IDLE_LIMIT = 300;
  localparam int DRAIN_CYC  = 40;

  // node count per subgraph; entries 8 and 9 reuse table slots 0 and 1
  int unsigned node_cnt_tab [NUM_SG_TB] = '{1, 4, 5, 3, 2, 7, 6, 1, 1, 4};

  // coefficients in stream order, one row per subgraph
  logic [COEF_W-1:0] coef_tab [NUM_COEF] = '{
    4'd7,
    4'd3, 4'd3, 4'd3, 4'd3,
    4'd0, 4'd15, 4'd4, 4'd9, 4'd15,
    4'd5, 4'd5, 4'd5,
    4'd15, 4'd0,
    4'd2, 4'd2, 4'd2, 4'd2, 4'd2, 4'd2, 4'd2,
    4'd8, 4'd8, 4'd1, 4'd14, 4'd3, 4'd0,
    4'd0,
    4'd15,
    4'd1, 4'd10, 4'd12, 4'd0
  };

  alpha_t exp_tab [NUM_COEF];

  logic   clk;
  logic   rst_n;
  logic   coef_valid;
  logic   coef_ready;
  coef_t  coef_in;
  logic   cfg_valid;
  cfg_t   cfg;
  logic   alpha_valid;
  logic   alpha_ready;
  alpha_t alpha;

  integer seed;
  int     mismatches;
  int     timeouts;
  int     other_errs;

  sm_attn_top u_sm_attn_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .coef_valid  (coef_valid),
    .coef_ready  (coef_ready),
    .coef_in     (coef_in),
    .cfg_valid   (cfg_valid),
    .cfg         (cfg),
    .alpha_valid (alpha_valid),
    .alpha_ready (alpha_ready),
    .alpha       (alpha)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // alpha = floor(2^e * 2^ALPHA_FRAC / sum of 2^e over the subgraph)
  task automatic build_expected();
    int              base;
    longint unsigned sum;
    longint unsigned term;
    base = 0;
    for (int s = 0; s < NUM_SG_TB; s++) begin
      sum = 0;
      for (int k = 0; k < node_cnt_tab[s]; k++) begin
        sum += 64'd1 << coef_tab[base+k];
      end
      for (int k = 0; k < node_cnt_tab[s]; k++) begin
        term = 64'd1 << coef_tab[base+k];
        exp_tab[base+k].value = ALPHA_W'((term << ALPHA_FRAC) / sum);
        exp_tab[base+k].last  = (k == node_cnt_tab[s] - 1);
      end
      base += node_cnt_tab[s];
    end
  endtask

  task automatic check_alpha(input alpha_t got, input alpha_t want, input int idx);
    if (got.value !== want.value) begin
      mismatches++;
      $display("[FAIL] alpha.value at %0d: got 0x%0h, expected 0x%0h",
               idx, got.value, want.value);
    end
    if (got.last !== want.last) begin
      mismatches++;
      $display("[FAIL] alpha.last at %0d: got 0x%0h, expected 0x%0h",
               idx, got.last, want.last);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
      mismatches++;
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, want);
    end
  endtask

  // called on a rising edge and returns on the edge that takes the word
  task automatic send_coef(input logic [COEF_W-1:0] v, input int idx);
    int waited;
    waited = 0;
    coef_valid    <= 1'b1;
    coef_in.value <= v;
    @(negedge clk);
    while (!coef_ready && waited < READY_WAIT) begin
      @(negedge clk);
      waited++;
    end
    if (!coef_ready) begin
      timeouts++;
      $display("timeout: coef_ready stayed low for coefficient %0d", idx);
    end
    @(posedge clk);
  endtask

  task automatic collect_alphas();
    int          got;
    int          idle;
    logic [31:0] rnd;
    got  = 0;
    idle = 0;
    while (got < NUM_COEF && idle < IDLE_LIMIT) begin
      @(posedge clk);
      rnd = $random(seed);
      alpha_ready <= rnd[0];
      @(negedge clk);
      if (alpha_valid && alpha_ready) begin
        check_alpha(alpha, exp_tab[got], got);
        got++;
        idle = 0;
      end else begin
        idle++;
      end
    end
    if (got < NUM_COEF) begin
      timeouts++;
      $display("timeout: only %0d of %0d alphas arrived", got, NUM_COEF);
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    coef_valid  = 1'b0;
    coef_in     = '0;
    cfg_valid   = 1'b0;
    cfg         = '0;
    alpha_ready = 1'b0;
    seed        = 32'h3254_85f5;
    mismatches  = 0;
    timeouts    = 0;
    other_errs  = 0;
    build_expected();

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // state right after reset
    @(negedge clk);
    check_flag("coef_ready", coef_ready, 1'b1);
    check_flag("alpha_valid", alpha_valid, 1'b0);
    @(posedge clk);

    // load the node-count table while the stream is idle
    for (int i = 0; i < NUM_SUBGRAPHS; i++) begin
      cfg_valid     <= 1'b1;
      cfg.sg        <= SG_W'(i);
      cfg.num_nodes <= CNT_W'(node_cnt_tab[i]);
      @(posedge clk);
    end
    cfg_valid <= 1'b0;
    repeat (2) @(posedge clk);

    fork
      begin
        for (int i = 0; i < NUM_COEF; i++) begin
          send_coef(coef_tab[i], i);
        end
        coef_valid <= 1'b0;
      end
      collect_alphas();
    join

    // nothing may follow the last expected alpha
    alpha_ready <= 1'b1;
    repeat (DRAIN_CYC) begin
      @(negedge clk);
      if (alpha_valid) begin
        other_errs++;
        $display("an extra alpha appeared after all expected ones were taken");
      end
    end

    $display("errors: %0d mismatches, %0d timeouts, %0d other",
             mismatches, timeouts, other_errs);
    if (mismatches + timeouts + other_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
